//--- design/l2_interface_pkg.sv
//////////////////////////////
// Widths, address fields, cache type and L1 geometry
// shared by the L1 to L2 bridge
//////////////////////////////

`default_nettype none

package l2_interface_pkg;

	// Thread count and L1 geometry for both caches
	localparam int num_threads = 4;
	localparam int l1_ways = 4;
	localparam int l1_sets = 64;
	localparam int cache_line_bytes = 16;

	// Address splits into offset, set index and tag from the bottom up
	localparam int set_lsb = $clog2(cache_line_bytes);
	localparam int tag_lsb = set_lsb + $clog2(l1_sets);

	typedef logic [31:0] scalar_t;
	typedef logic [$clog2(num_threads) - 1:0] thread_idx_t;
	typedef logic [num_threads - 1:0] thread_bitmap_t;
	typedef logic [cache_line_bytes * 8 - 1:0] cache_line_data_t;
	typedef logic [3:0] core_id_t;

	typedef logic [$clog2(l1_sets) - 1:0] l1_set_idx_t;
	typedef logic [31 - tag_lsb:0] l1_tag_t;
	typedef logic [$clog2(l1_ways) - 1:0] l1_way_idx_t;

	// Which L1 a request or response belongs to
	typedef enum logic
	{
		ct_icache,
		ct_dcache
	} cache_type_t;

endpackage

`default_nettype wire

//--- design/load_miss_queue.sv
//////////////////////////////
// Pending load-miss entries per thread, with line collapse,
// request selection and wake-up
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module load_miss_queue
	(
		input wire clk,
		input wire reset,

		// Miss strobe from the L1
		input wire cache_miss,
		input wire l2_interface_pkg::scalar_t cache_miss_addr,
		input wire l2_interface_pkg::thread_idx_t cache_miss_thread,

		// Request towards the L2 arbiter
		output logic request_ready,
		output l2_interface_pkg::scalar_t request_addr,
		output l2_interface_pkg::thread_idx_t request_id,
		input wire request_ack,

		// Response from stage 2
		input wire response_valid,
		input wire l2_interface_pkg::thread_idx_t response_id,
		output l2_interface_pkg::thread_bitmap_t wake_bitmap
	);

	localparam int num_entries = l2_interface_pkg::num_threads;

	logic [num_entries - 1:0] entry_valid;
	logic [num_entries - 1:0] entry_pending;
	l2_interface_pkg::scalar_t entry_addr[num_entries];
	l2_interface_pkg::thread_bitmap_t entry_waiting[num_entries];
	logic [num_entries - 1:0] collapse_oh;
	logic collapse;
	l2_interface_pkg::thread_idx_t collapse_idx;
	l2_interface_pkg::thread_idx_t pending_idx;
	logic locked;
	l2_interface_pkg::thread_idx_t locked_idx;
	l2_interface_pkg::scalar_t miss_line;
	l2_interface_pkg::thread_bitmap_t miss_thread_oh;

	assign miss_line = cache_miss_addr
		& ~l2_interface_pkg::scalar_t'(l2_interface_pkg::cache_line_bytes - 1);
	assign miss_thread_oh = l2_interface_pkg::thread_bitmap_t'(1) << cache_miss_thread;

	// An entry freed this cycle takes no collapsed miss
	// because its threads are already being woken
	always_comb
	begin
		for (int i = 0; i < num_entries; i++)
		begin
			collapse_oh[i] = entry_valid[i] && entry_addr[i] == miss_line
				&& !(response_valid && response_id == l2_interface_pkg::thread_idx_t'(i));
		end
	end

	assign collapse = |collapse_oh;

	// Lowest-numbered match and lowest-numbered pending entry
	always_comb
	begin
		collapse_idx = '0;
		pending_idx = '0;
		for (int i = num_entries - 1; i >= 0; i--)
		begin
			if (collapse_oh[i])
				collapse_idx = l2_interface_pkg::thread_idx_t'(i);

			if (entry_pending[i])
				pending_idx = l2_interface_pkg::thread_idx_t'(i);
		end
	end

	// A stalled request keeps its entry until the L2 takes it
	assign request_ready = |entry_pending;
	assign request_id = locked ? locked_idx : pending_idx;
	assign request_addr = entry_addr[request_id];
	assign wake_bitmap = response_valid ? entry_waiting[response_id] : '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_pending <= '0;
			locked <= 1'b0;
			locked_idx <= '0;
		end
		else
		begin
			if (response_valid)
				entry_valid[response_id] <= 1'b0;

			if (request_ack)
				entry_pending[request_id] <= 1'b0;

			// New line goes into the missing thread's own entry
			if (cache_miss && !collapse)
			begin
				entry_valid[cache_miss_thread] <= 1'b1;
				entry_pending[cache_miss_thread] <= 1'b1;
			end

			locked <= request_ready && !request_ack;
			locked_idx <= request_id;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cache_miss)
		begin
			if (collapse)
				entry_waiting[collapse_idx] <= entry_waiting[collapse_idx] | miss_thread_oh;
			else
			begin
				entry_addr[cache_miss_thread] <= miss_line;
				entry_waiting[cache_miss_thread] <= miss_thread_oh;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/l2_transfer_control.sv
//////////////////////////////
// L2 request arbitration, response stage register and
// decode into tag, data and wake strobes
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module l2_transfer_control
	#(parameter l2_interface_pkg::core_id_t CORE_ID = '0)
	(
		input wire clk,
		input wire reset,

		// L2 request port
		output logic l2_request_valid,
		output l2_interface_pkg::cache_type_t l2_request_cache_type,
		output l2_interface_pkg::thread_idx_t l2_request_id,
		output l2_interface_pkg::scalar_t l2_request_address,
		output l2_interface_pkg::core_id_t l2_request_core,
		input wire l2_ready,

		// L2 response port
		input wire l2_response_valid,
		input wire l2_interface_pkg::core_id_t response_core,
		input wire l2_interface_pkg::cache_type_t response_cache_type,
		input wire l2_interface_pkg::thread_idx_t response_id,
		input wire l2_interface_pkg::scalar_t response_address,
		input wire l2_interface_pkg::cache_line_data_t response_data,

		// Miss queues
		input wire dcache_request_ready,
		input wire l2_interface_pkg::scalar_t dcache_request_addr,
		input wire l2_interface_pkg::thread_idx_t dcache_request_id,
		input wire icache_request_ready,
		input wire l2_interface_pkg::scalar_t icache_request_addr,
		input wire l2_interface_pkg::thread_idx_t icache_request_id,
		output logic dcache_request_ack,
		output logic icache_request_ack,
		output logic dcache_response_valid,
		output logic icache_response_valid,
		output l2_interface_pkg::thread_idx_t stage_response_id,

		// Stage 1 snoop and LRU fill
		output logic snoop_en,
		output l2_interface_pkg::l1_set_idx_t snoop_set,
		output logic dcache_lru_fill_en,
		output logic icache_lru_fill_en,
		output l2_interface_pkg::l1_set_idx_t lru_fill_set,

		// Stage 2 way choice and tag writes
		input wire snoop_hit,
		input wire l2_interface_pkg::l1_way_idx_t dcache_update_way,
		input wire l2_interface_pkg::l1_way_idx_t icache_fill_lru,
		output l2_interface_pkg::l1_tag_t stage_tag,
		output l2_interface_pkg::l1_set_idx_t stage_set,
		output logic [l2_interface_pkg::l1_ways - 1:0] dtag_update_en_oh,
		output logic [l2_interface_pkg::l1_ways - 1:0] itag_update_en_oh,
		output l2_interface_pkg::l1_tag_t tag_update_tag,
		output l2_interface_pkg::l1_set_idx_t tag_update_set,

		// Towards the stage 3 data registers
		output logic dcache_data_en,
		output logic icache_data_en,
		output l2_interface_pkg::cache_line_data_t stage_data
	);

	typedef logic [l2_interface_pkg::l1_ways - 1:0] way_oh_t;

	logic send_dcache;
	logic send_icache;
	logic icache_hold;
	logic response_for_me;
	logic stage_valid;
	logic stage_for_me;
	l2_interface_pkg::core_id_t stage_core;
	l2_interface_pkg::cache_type_t stage_cache_type;
	l2_interface_pkg::scalar_t stage_address;

	//////////////////////////////
	// Request arbitration
	//////////////////////////////

	// Data cache wins unless a stalled icache request is still waiting
	assign send_dcache = dcache_request_ready && !icache_hold;
	assign send_icache = !send_dcache && icache_request_ready;

	assign l2_request_valid = send_dcache || send_icache;
	assign l2_request_cache_type = send_dcache ? l2_interface_pkg::ct_dcache
		: l2_interface_pkg::ct_icache;
	assign l2_request_id = send_dcache ? dcache_request_id : icache_request_id;
	assign l2_request_address = send_dcache ? dcache_request_addr : icache_request_addr;
	assign l2_request_core = CORE_ID;
	assign dcache_request_ack = send_dcache && l2_ready;
	assign icache_request_ack = send_icache && l2_ready;

	//////////////////////////////
	// Stage 1
	//////////////////////////////

	assign response_for_me = response_core == CORE_ID;
	assign snoop_en = l2_response_valid && response_cache_type == l2_interface_pkg::ct_dcache;
	assign snoop_set = response_address[l2_interface_pkg::set_lsb
		+: $bits(l2_interface_pkg::l1_set_idx_t)];
	assign dcache_lru_fill_en = snoop_en && response_for_me;
	assign icache_lru_fill_en = l2_response_valid && response_for_me
		&& response_cache_type == l2_interface_pkg::ct_icache;
	assign lru_fill_set = snoop_set;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			icache_hold <= 1'b0;
			stage_valid <= 1'b0;
		end
		else
		begin
			icache_hold <= send_icache && !l2_ready;
			stage_valid <= l2_response_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		stage_core <= response_core;
		stage_cache_type <= response_cache_type;
		stage_response_id <= response_id;
		stage_address <= response_address;
		stage_data <= response_data;
	end

	//////////////////////////////
	// Stage 2
	//////////////////////////////

	assign stage_tag = stage_address[l2_interface_pkg::tag_lsb
		+: $bits(l2_interface_pkg::l1_tag_t)];
	assign stage_set = stage_address[l2_interface_pkg::set_lsb
		+: $bits(l2_interface_pkg::l1_set_idx_t)];

	// Only our own load acks fill tags and wake threads
	assign stage_for_me = stage_valid && stage_core == CORE_ID;
	assign dcache_response_valid = stage_for_me
		&& stage_cache_type == l2_interface_pkg::ct_dcache;
	assign icache_response_valid = stage_for_me
		&& stage_cache_type == l2_interface_pkg::ct_icache;

	assign dtag_update_en_oh = dcache_response_valid ? way_oh_t'(1) << dcache_update_way : '0;
	assign itag_update_en_oh = icache_response_valid ? way_oh_t'(1) << icache_fill_lru : '0;
	assign tag_update_tag = stage_tag;
	assign tag_update_set = stage_set;

	// Another core's line still refreshes a copy we hold
	assign dcache_data_en = dcache_response_valid || (stage_valid && snoop_hit
		&& stage_cache_type == l2_interface_pkg::ct_dcache);
	assign icache_data_en = icache_response_valid;

endmodule

`default_nettype wire

//--- design/snoop_way_select.sv
//////////////////////////////
// Data-cache snoop compare and update-way choice
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module snoop_way_select
	(
		input wire l2_interface_pkg::l1_tag_t stage_tag,
		input wire snoop_valid[l2_interface_pkg::l1_ways],
		input wire l2_interface_pkg::l1_tag_t snoop_tag[l2_interface_pkg::l1_ways],
		input wire l2_interface_pkg::l1_way_idx_t dcache_fill_lru,
		output logic snoop_hit,
		output l2_interface_pkg::l1_way_idx_t update_way
	);

	logic [l2_interface_pkg::l1_ways - 1:0] hit_oh;
	l2_interface_pkg::l1_way_idx_t hit_way;

	genvar way_idx;
	generate
		for (way_idx = 0; way_idx < l2_interface_pkg::l1_ways; way_idx++)
		begin : way_compare_gen
			assign hit_oh[way_idx] = snoop_valid[way_idx]
				&& snoop_tag[way_idx] == stage_tag;
		end
	endgenerate

	// A line sits in one way at most, so OR the indices together
	always_comb
	begin
		hit_way = '0;
		for (int i = 0; i < l2_interface_pkg::l1_ways; i++)
		begin
			if (hit_oh[i])
				hit_way = hit_way | l2_interface_pkg::l1_way_idx_t'(i);
		end
	end

	assign snoop_hit = |hit_oh;

	// Refresh the resident line, else fill the LRU way
	assign update_way = snoop_hit ? hit_way : dcache_fill_lru;

endmodule

`default_nettype wire

//--- design/l1_data_update.sv
//////////////////////////////
// Stage 3 registers for both L1 data memory writes
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module l1_data_update
	(
		input wire clk,
		input wire reset,

		// From stage 2
		input wire dcache_data_en,
		input wire icache_data_en,
		input wire l2_interface_pkg::l1_way_idx_t dcache_way,
		input wire l2_interface_pkg::l1_way_idx_t icache_way,
		input wire l2_interface_pkg::l1_set_idx_t stage_set,
		input wire l2_interface_pkg::cache_line_data_t stage_data,

		// Data cache write
		output logic ddata_update_en,
		output l2_interface_pkg::l1_way_idx_t ddata_update_way,
		output l2_interface_pkg::l1_set_idx_t ddata_update_set,
		output l2_interface_pkg::cache_line_data_t ddata_update_data,

		// Instruction cache write
		output logic idata_update_en,
		output l2_interface_pkg::l1_way_idx_t idata_update_way,
		output l2_interface_pkg::l1_set_idx_t idata_update_set,
		output l2_interface_pkg::cache_line_data_t idata_update_data
	);

	// Data lands one cycle after the tag so a load never sees
	// a new tag with stale data
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ddata_update_en <= 1'b0;
			idata_update_en <= 1'b0;
		end
		else
		begin
			ddata_update_en <= dcache_data_en;
			idata_update_en <= icache_data_en;
		end
	end

	// Payload only loads on a write
	always_ff @(posedge clk)
	begin
		if (dcache_data_en)
		begin
			ddata_update_way <= dcache_way;
			ddata_update_set <= stage_set;
			ddata_update_data <= stage_data;
		end

		if (icache_data_en)
		begin
			idata_update_way <= icache_way;
			idata_update_set <= stage_set;
			idata_update_data <= stage_data;
		end
	end

endmodule

`default_nettype wire

//--- design/l2_cache_interface.sv
//////////////////////////////
// Top level of the L1 to L2 load-miss bridge
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module l2_cache_interface
	#(parameter l2_interface_pkg::core_id_t CORE_ID = '0)
	(
		input wire clk,
		input wire reset,

		// L2 request port
		output logic l2_request_valid,
		output l2_interface_pkg::cache_type_t l2_request_cache_type,
		output l2_interface_pkg::thread_idx_t l2_request_id,
		output l2_interface_pkg::scalar_t l2_request_address,
		output l2_interface_pkg::core_id_t l2_request_core,
		input wire l2_ready,

		// L2 response port
		input wire l2_response_valid,
		input wire l2_interface_pkg::core_id_t response_core,
		input wire l2_interface_pkg::cache_type_t response_cache_type,
		input wire l2_interface_pkg::thread_idx_t response_id,
		input wire l2_interface_pkg::scalar_t response_address,
		input wire l2_interface_pkg::cache_line_data_t response_data,

		// L1 misses
		input wire dcache_miss,
		input wire l2_interface_pkg::scalar_t dcache_miss_addr,
		input wire l2_interface_pkg::thread_idx_t dcache_miss_thread,
		input wire icache_miss,
		input wire l2_interface_pkg::scalar_t icache_miss_addr,
		input wire l2_interface_pkg::thread_idx_t icache_miss_thread,

		// L1 tag memories
		output logic snoop_en,
		output l2_interface_pkg::l1_set_idx_t snoop_set,
		input wire snoop_valid[l2_interface_pkg::l1_ways],
		input wire l2_interface_pkg::l1_tag_t snoop_tag[l2_interface_pkg::l1_ways],
		input wire l2_interface_pkg::l1_way_idx_t dcache_fill_lru,
		input wire l2_interface_pkg::l1_way_idx_t icache_fill_lru,
		output logic dcache_lru_fill_en,
		output logic icache_lru_fill_en,
		output l2_interface_pkg::l1_set_idx_t lru_fill_set,
		output logic [l2_interface_pkg::l1_ways - 1:0] dtag_update_en_oh,
		output logic [l2_interface_pkg::l1_ways - 1:0] itag_update_en_oh,
		output l2_interface_pkg::l1_tag_t tag_update_tag,
		output l2_interface_pkg::l1_set_idx_t tag_update_set,

		// L1 data memories
		output logic ddata_update_en,
		output l2_interface_pkg::l1_way_idx_t ddata_update_way,
		output l2_interface_pkg::l1_set_idx_t ddata_update_set,
		output l2_interface_pkg::cache_line_data_t ddata_update_data,
		output logic idata_update_en,
		output l2_interface_pkg::l1_way_idx_t idata_update_way,
		output l2_interface_pkg::l1_set_idx_t idata_update_set,
		output l2_interface_pkg::cache_line_data_t idata_update_data,

		// Thread wake-up
		output l2_interface_pkg::thread_bitmap_t dcache_wake_bitmap,
		output l2_interface_pkg::thread_bitmap_t icache_wake_bitmap
	);

	logic dcache_request_ready;
	l2_interface_pkg::scalar_t dcache_request_addr;
	l2_interface_pkg::thread_idx_t dcache_request_id;
	logic dcache_request_ack;
	logic icache_request_ready;
	l2_interface_pkg::scalar_t icache_request_addr;
	l2_interface_pkg::thread_idx_t icache_request_id;
	logic icache_request_ack;
	logic dcache_response_valid;
	logic icache_response_valid;
	l2_interface_pkg::thread_idx_t stage_response_id;
	logic snoop_hit;
	l2_interface_pkg::l1_way_idx_t dcache_update_way;
	l2_interface_pkg::l1_tag_t stage_tag;
	l2_interface_pkg::l1_set_idx_t stage_set;
	logic dcache_data_en;
	logic icache_data_en;
	l2_interface_pkg::cache_line_data_t stage_data;

	load_miss_queue dcache_miss_queue(
		.clk(clk),
		.reset(reset),
		.cache_miss(dcache_miss),
		.cache_miss_addr(dcache_miss_addr),
		.cache_miss_thread(dcache_miss_thread),
		.request_ready(dcache_request_ready),
		.request_addr(dcache_request_addr),
		.request_id(dcache_request_id),
		.request_ack(dcache_request_ack),
		.response_valid(dcache_response_valid),
		.response_id(stage_response_id),
		.wake_bitmap(dcache_wake_bitmap));

	load_miss_queue icache_miss_queue(
		.clk(clk),
		.reset(reset),
		.cache_miss(icache_miss),
		.cache_miss_addr(icache_miss_addr),
		.cache_miss_thread(icache_miss_thread),
		.request_ready(icache_request_ready),
		.request_addr(icache_request_addr),
		.request_id(icache_request_id),
		.request_ack(icache_request_ack),
		.response_valid(icache_response_valid),
		.response_id(stage_response_id),
		.wake_bitmap(icache_wake_bitmap));

	// Arbiter, response stages and strobe decode
	l2_transfer_control #(.CORE_ID(CORE_ID)) l2_transfer_control(.*);

	snoop_way_select snoop_way_select(
		.update_way(dcache_update_way),
		.*);

	l1_data_update l1_data_update(
		.dcache_way(dcache_update_way),
		.icache_way(icache_fill_lru),
		.*);

endmodule

`default_nettype wire

//--- sim/l2_cache_interface_tb.sv
//////////////////////////////
// Testbench for the L1 to L2 load-miss bridge, with L1 tag
// memory and L2 models driven from the stimulus file
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module l2_cache_interface_tb;

	localparam l2_interface_pkg::core_id_t CORE_ID = 4'd3;
	localparam int wait_limit = 20;

	logic clk;
	logic reset;
	logic l2_request_valid;
	l2_interface_pkg::cache_type_t l2_request_cache_type;
	l2_interface_pkg::thread_idx_t l2_request_id;
	l2_interface_pkg::scalar_t l2_request_address;
	l2_interface_pkg::core_id_t l2_request_core;
	logic l2_ready;
	logic l2_response_valid;
	l2_interface_pkg::core_id_t response_core;
	l2_interface_pkg::cache_type_t response_cache_type;
	l2_interface_pkg::thread_idx_t response_id;
	l2_interface_pkg::scalar_t response_address;
	l2_interface_pkg::cache_line_data_t response_data;
	logic dcache_miss;
	l2_interface_pkg::scalar_t dcache_miss_addr;
	l2_interface_pkg::thread_idx_t dcache_miss_thread;
	logic icache_miss;
	l2_interface_pkg::scalar_t icache_miss_addr;
	l2_interface_pkg::thread_idx_t icache_miss_thread;
	logic snoop_en;
	l2_interface_pkg::l1_set_idx_t snoop_set;
	logic snoop_valid[l2_interface_pkg::l1_ways];
	l2_interface_pkg::l1_tag_t snoop_tag[l2_interface_pkg::l1_ways];
	l2_interface_pkg::l1_way_idx_t dcache_fill_lru;
	l2_interface_pkg::l1_way_idx_t icache_fill_lru;
	logic dcache_lru_fill_en;
	logic icache_lru_fill_en;
	l2_interface_pkg::l1_set_idx_t lru_fill_set;
	logic [l2_interface_pkg::l1_ways - 1:0] dtag_update_en_oh;
	logic [l2_interface_pkg::l1_ways - 1:0] itag_update_en_oh;
	l2_interface_pkg::l1_tag_t tag_update_tag;
	l2_interface_pkg::l1_set_idx_t tag_update_set;
	logic ddata_update_en;
	l2_interface_pkg::l1_way_idx_t ddata_update_way;
	l2_interface_pkg::l1_set_idx_t ddata_update_set;
	l2_interface_pkg::cache_line_data_t ddata_update_data;
	logic idata_update_en;
	l2_interface_pkg::l1_way_idx_t idata_update_way;
	l2_interface_pkg::l1_set_idx_t idata_update_set;
	l2_interface_pkg::cache_line_data_t idata_update_data;
	l2_interface_pkg::thread_bitmap_t dcache_wake_bitmap;
	l2_interface_pkg::thread_bitmap_t icache_wake_bitmap;

	int checks;
	int value_errors;
	int run_errors;
	int cycle_count;
	int resp_cycle;
	logic aborted;
	logic [31:0] rng_state;
	l2_interface_pkg::cache_line_data_t resp_line;

	l2_cache_interface #(.CORE_ID(CORE_ID)) dut_i(.*);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	//////////////////////////////
	// Checking helpers
	//////////////////////////////

	task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic report_timeout(input string what);
		run_errors++;
		aborted = 1'b1;
		$display("Timeout: %s did not show up within %0d cycles", what, wait_limit);
	endtask

	// Inputs change 5 ns after the rising edge
	task automatic next_cycle;
		@(posedge clk);
		#5;
		cycle_count++;
	endtask

	//////////////////////////////
	// Stimulus commands
	//////////////////////////////

	task automatic drive_miss(input logic [31:0] f[11]);
		dcache_miss = f[0][0];
		dcache_miss_addr = f[1];
		dcache_miss_thread = f[2][1:0];
		icache_miss = f[3][0];
		icache_miss_addr = f[4];
		icache_miss_thread = f[5][1:0];
		next_cycle();
		dcache_miss = 1'b0;
		icache_miss = 1'b0;
	endtask

	task automatic drive_response(input logic [31:0] f[11]);
		logic is_dcache;
		logic for_me;
		is_dcache = f[1][0];
		for_me = f[0][3:0] == CORE_ID;
		for (int i = 0; i < 4; i++)
		begin
			rng_state = xorshift32(rng_state);
			resp_line[i * 32 +: 32] = rng_state;
		end
		response_core = f[0][3:0];
		response_cache_type = l2_interface_pkg::cache_type_t'(f[1][0]);
		response_id = f[2][1:0];
		response_address = f[3];
		response_data = resp_line;
		// Tag memory model holds its answer until the next response
		for (int i = 0; i < l2_interface_pkg::l1_ways; i++)
			snoop_valid[i] = f[4][i];
		snoop_tag[0] = f[5][21:0];
		snoop_tag[1] = f[6][21:0];
		snoop_tag[2] = f[7][21:0];
		snoop_tag[3] = f[8][21:0];
		dcache_fill_lru = f[9][1:0];
		icache_fill_lru = f[10][1:0];
		l2_response_valid = 1'b1;
		resp_cycle = cycle_count;
		#1;
		check_value(snoop_en, is_dcache, "snoop_en");
		check_value(snoop_set, f[3][9:4], "snoop_set");
		check_value(dcache_lru_fill_en, is_dcache && for_me, "dcache_lru_fill_en");
		check_value(icache_lru_fill_en, !is_dcache && for_me, "icache_lru_fill_en");
		check_value(lru_fill_set, f[3][9:4], "lru_fill_set");
		next_cycle();
		l2_response_valid = 1'b0;
	endtask

	task automatic expect_request(input logic [31:0] f[11]);
		int n;
		n = 0;
		#1;
		while (!l2_request_valid && n < wait_limit)
		begin
			next_cycle();
			#1;
			n++;
		end
		if (!l2_request_valid)
			report_timeout("L2 request");
		else
		begin
			check_value(l2_request_cache_type, f[0][0], "request cache type");
			check_value(l2_request_id, f[1][1:0], "request id");
			check_value(l2_request_address, f[2], "request address");
			check_value(l2_request_core, CORE_ID, "request core");
		end
	endtask

	task automatic expect_tag(input logic [31:0] f[11]);
		int n;
		logic [3:0] oh;
		n = 0;
		#1;
		oh = f[0][0] ? dtag_update_en_oh : itag_update_en_oh;
		while (oh == '0 && n < wait_limit)
		begin
			next_cycle();
			#1;
			oh = f[0][0] ? dtag_update_en_oh : itag_update_en_oh;
			n++;
		end
		if (oh == '0)
			report_timeout("tag update");
		else
		begin
			check_value(oh, 4'b0001 << f[1][1:0], "tag update way");
			check_value(tag_update_tag, f[2][21:0], "tag update tag");
			check_value(tag_update_set, f[3][5:0], "tag update set");
			check_value(cycle_count - resp_cycle, 1, "tag update delay");
		end
	endtask

	task automatic expect_data(input logic [31:0] f[11]);
		int n;
		n = 0;
		#1;
		while (!(f[0][0] ? ddata_update_en : idata_update_en) && n < wait_limit)
		begin
			next_cycle();
			#1;
			n++;
		end
		if (!(f[0][0] ? ddata_update_en : idata_update_en))
			report_timeout("data update");
		else
		begin
			if (f[0][0])
			begin
				check_value(ddata_update_way, f[1][1:0], "dcache data way");
				check_value(ddata_update_set, f[2][5:0], "dcache data set");
				check_value(ddata_update_data, resp_line, "dcache data line");
				check_value(cycle_count - resp_cycle, 2, "dcache data delay");
			end
			else
			begin
				check_value(idata_update_way, f[1][1:0], "icache data way");
				check_value(idata_update_set, f[2][5:0], "icache data set");
				check_value(idata_update_data, resp_line, "icache data line");
				check_value(cycle_count - resp_cycle, 2, "icache data delay");
			end
			// Step past the one-cycle write strobe
			next_cycle();
		end
	endtask

	task automatic expect_wake(input logic [31:0] f[11]);
		int n;
		l2_interface_pkg::thread_bitmap_t wake;
		n = 0;
		#1;
		wake = f[0][0] ? dcache_wake_bitmap : icache_wake_bitmap;
		while (wake == '0 && n < wait_limit)
		begin
			next_cycle();
			#1;
			wake = f[0][0] ? dcache_wake_bitmap : icache_wake_bitmap;
			n++;
		end
		if (wake == '0)
			report_timeout("wake bitmap");
		else
		begin
			check_value(wake, f[1][3:0], "wake bitmap");
			check_value(cycle_count - resp_cycle, 1, "wake delay");
		end
	endtask

	// No tag write, no wake and no data write for a number of cycles
	task automatic expect_idle(input int cycles);
		repeat (cycles)
		begin
			#1;
			check_value(dtag_update_en_oh, 0, "dtag_update_en_oh while idle");
			check_value(itag_update_en_oh, 0, "itag_update_en_oh while idle");
			check_value(dcache_wake_bitmap, 0, "dcache wake while idle");
			check_value(icache_wake_bitmap, 0, "icache wake while idle");
			check_value(ddata_update_en, 0, "ddata_update_en while idle");
			check_value(idata_update_en, 0, "idata_update_en while idle");
			next_cycle();
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int fd;
		string line;
		logic [31:0] f[11];
		byte cmd;
		checks = 0;
		value_errors = 0;
		run_errors = 0;
		cycle_count = 0;
		resp_cycle = 0;
		aborted = 1'b0;
		rng_state = 32'h8cb0b516;
		resp_line = '0;
		reset = 1'b1;
		l2_ready = 1'b0;
		l2_response_valid = 1'b0;
		response_core = '0;
		response_cache_type = l2_interface_pkg::ct_icache;
		response_id = '0;
		response_address = '0;
		response_data = '0;
		dcache_miss = 1'b0;
		dcache_miss_addr = '0;
		dcache_miss_thread = '0;
		icache_miss = 1'b0;
		icache_miss_addr = '0;
		icache_miss_thread = '0;
		for (int i = 0; i < l2_interface_pkg::l1_ways; i++)
		begin
			snoop_valid[i] = 1'b0;
			snoop_tag[i] = '0;
		end
		dcache_fill_lru = '0;
		icache_fill_lru = '0;
		repeat (4)
			@(posedge clk);
		#5;
		reset = 1'b0;
		#1;
		check_value(l2_request_valid, 0, "request valid after reset");
		check_value(dcache_wake_bitmap, 0, "dcache wake after reset");
		check_value(icache_wake_bitmap, 0, "icache wake after reset");
		check_value(ddata_update_en, 0, "ddata_update_en after reset");
		check_value(idata_update_en, 0, "idata_update_en after reset");
		fd = $fopen("sim/l2_stimulus.txt", "r");
		if (fd == 0)
		begin
			run_errors++;
			aborted = 1'b1;
			$display("Could not open the stimulus file sim/l2_stimulus.txt");
		end
		while (!aborted && !$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#")
			begin
				cmd = line.getc(0);
				for (int i = 0; i < 11; i++)
					f[i] = '0;
				void'($sscanf(line.substr(1, line.len() - 1),
					"%h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]));
				case (cmd)
					"M": drive_miss(f);
					"R": drive_response(f);
					"L": l2_ready = f[0][0];
					"W": repeat (f[0]) next_cycle();
					"Q": expect_request(f);
					"N":
					begin
						#1;
						check_value(l2_request_valid, 0, "request valid");
					end
					"T": expect_tag(f);
					"D": expect_data(f);
					"K": expect_wake(f);
					"I": expect_idle(f[0]);
					default:
					begin
						run_errors++;
						$display("Unknown stimulus command in line: %s", line);
					end
				endcase
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, run_errors);
		if (value_errors == 0 && run_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/l2_stimulus.txt
# M dmiss daddr dthread imiss iaddr ithread | R core ctype id addr snoopvalid tag0-3 dlru ilru
# L ready | W cycles | Q ctype id addr | N | T ctype way tag set | D ctype way set | K ctype bitmap | I cycles
L 0
M 1 00001230 2 0 00000000 0
Q 1 2 00001230
W 3
Q 1 2 00001230
L 1
W 1
N
R 3 1 2 00001230 0 000000 000000 000000 000000 2 0
T 1 2 000004 23
K 1 4
D 1 2 23
L 0
M 1 00003000 0 1 00002000 1
Q 1 0 00003000
L 1
W 1
Q 0 1 00002000
W 1
N
R 3 1 0 00003000 2 000000 00000C 000000 000000 3 0
T 1 1 00000C 00
K 1 1
D 1 1 00
R 3 0 1 00002000 0 000000 000000 000000 000000 0 2
T 0 2 000008 00
K 0 2
D 0 2 00
L 0
M 1 00004000 1 0 00000000 0
M 1 00004000 3 0 00000000 0
Q 1 1 00004000
L 1
W 1
N
W 2
N
R 3 1 1 00004000 0 000000 000000 000000 000000 0 0
T 1 0 000010 00
K 1 a
D 1 0 00
R 5 1 0 00005000 0 000000 000000 000000 000000 1 0
I 3
R 5 1 0 00005000 4 000000 000000 000014 000000 0 0
I 1
D 1 2 00
I 2

//--- src.f
design/l2_interface_pkg.sv
design/load_miss_queue.sv
design/l2_transfer_control.sv
design/snoop_way_select.sv
design/l1_data_update.sv
design/l2_cache_interface.sv
sim/l2_cache_interface_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary -j 0
TOP = l2_cache_interface_tb
FILELIST = src.f
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
